// ==== ga_alu.f ====
hdl/ga_pkg.sv
hdl/ga_req_if.sv
hdl/ga_request_fifo.sv
hdl/ga_lane_math.sv
hdl/ga_lane_engine.sv
hdl/ga_alu_top.sv
verif/ga_alu_tb.sv

// ==== hdl/ga_alu_top.sv ====
`timescale 1ns/1ps

module ga_alu_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           valid_i,
    input  ga_pkg::ga_op_e operation_i,
    input  ga_pkg::ga_mv_t operand_a_i,
    input  ga_pkg::ga_mv_t operand_b_i,
    output logic           ready_o,
    output ga_pkg::ga_mv_t result_o,
    output logic           valid_o
);

    ga_req_if req_if ();

    // requests queue here while the engine works through lanes
    ga_request_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_request_fifo (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .push_valid_i (valid_i),
        .push_op_i    (operation_i),
        .push_a_i     (operand_a_i),
        .push_b_i     (operand_b_i),
        .push_ready_o (ready_o),
        .req          (req_if.fifo_side)
    );

    ga_lane_engine u_lane_engine (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req      (req_if.engine_side),
        .result_o (result_o),
        .valid_o  (valid_o)
    );

endmodule

// ==== hdl/ga_lane_engine.sv ====
`timescale 1ns/1ps

module ga_lane_engine (
    input  logic           clk_i,
    input  logic           rst_ni,
    ga_req_if.engine_side  req,
    output ga_pkg::ga_mv_t result_o,
    output logic           valid_o
);
    import ga_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e       state_q;
    state_e       state_d;
    ga_lane_idx_t lane_q;
    logic         valid_q;
    ga_op_e       op_q;
    ga_mv_t       a_q;
    ga_mv_t       b_q;
    ga_mv_t       result_q;
    ga_coef_t     lane_coef;

    // pop only when idle and the FIFO has an entry
    assign req.ready = (state_q == IDLE) && req.valid;

    ga_lane_math u_lane_math (
        .op_i   (op_q),
        .lane_i (lane_q),
        .a_i    (a_q),
        .b_i    (b_q),
        .coef_o (lane_coef)
    );

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req.ready) begin
                    state_d = RUN;
                end
            end
            RUN: begin
                if (lane_q == ga_lane_idx_t'(N_LANES - 1)) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
            lane_q  <= '0;
            valid_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // one cycle pulse, lane 15 is already in place
            valid_q <= (state_q == DONE);
            if (state_q == RUN) begin
                lane_q <= lane_q + 1'b1;
            end else begin
                lane_q <= '0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req.ready) begin
            op_q <= req.op;
            a_q  <= req.a;
            b_q  <= req.b;
        end
        if (state_q == RUN) begin
            result_q[lane_q*COEF_W +: COEF_W] <= lane_coef;
        end
    end

    // result holds until the next request starts writing lanes
    assign result_o = result_q;
    assign valid_o  = valid_q;

endmodule

// ==== hdl/ga_lane_math.sv ====
`timescale 1ns/1ps

module ga_lane_math (
    input  ga_pkg::ga_op_e       op_i,
    input  ga_pkg::ga_lane_idx_t lane_i,
    input  ga_pkg::ga_mv_t       a_i,
    input  ga_pkg::ga_mv_t       b_i,
    output ga_pkg::ga_coef_t     coef_o
);
    import ga_pkg::*;

    ga_blade_mask_t out_mask;
    ga_acc_t        term [N_LANES];
    ga_acc_t        prod_sum;
    ga_coef_t       a_lane;
    ga_coef_t       b_lane;
    logic           is_grade2;

    assign out_mask  = LANE_MASK[lane_i];
    assign a_lane    = a_i[lane_i*COEF_W +: COEF_W];
    assign b_lane    = b_i[lane_i*COEF_W +: COEF_W];
    assign is_grade2 = ($countones(out_mask) == 2);

    // one multiplier per input lane of a
    for (genvar j = 0; j < N_LANES; j++) begin : g_term
        ga_blade_mask_t             partner_mask;
        ga_lane_idx_t               partner_lane;
        ga_coef_t                   a_coef;
        ga_coef_t                   b_coef;
        logic signed [2*COEF_W-1:0] prod;
        logic                       keep;
        logic                       negate;

        // b lane that lands on the output blade together with a lane j
        assign partner_mask = LANE_MASK[j] ^ out_mask;
        assign partner_lane = mask_to_lane(partner_mask);
        assign a_coef       = a_i[j*COEF_W +: COEF_W];

        // norm squares each a lane
        assign b_coef = (op_i == OP_NORM) ? a_coef
                                          : b_i[partner_lane*COEF_W +: COEF_W];
        assign prod   = a_coef * b_coef;

        // outer product drops pairs that share a basis vector
        assign keep   = (op_i != OP_WEDGE) || ((LANE_MASK[j] & partner_mask) == '0);
        assign negate = (op_i != OP_NORM) && (blade_sign(LANE_MASK[j], partner_mask) < 0);

        assign term[j] = !keep  ? '0 :
                         negate ? -ga_acc_t'(prod) : ga_acc_t'(prod);
    end

    always_comb begin
        prod_sum = '0;
        for (int j = 0; j < N_LANES; j++) begin
            prod_sum = prod_sum + term[j];
        end
    end

    always_comb begin
        case (op_i)
            OP_ADD: begin
                coef_o = sat_add(a_lane, b_lane);
            end
            OP_SUB: begin
                coef_o = sat_coef(ga_acc_t'(a_lane) - ga_acc_t'(b_lane));
            end
            OP_MUL, OP_WEDGE: begin
                coef_o = round_sat(prod_sum);
            end
            OP_REV: begin
                // only bivectors flip sign under reversion
                coef_o = is_grade2 ? sat_coef(-ga_acc_t'(a_lane)) : a_lane;
            end
            OP_NORM: begin
                coef_o = (lane_i == '0) ? round_sat(prod_sum) : '0;
            end
            default: begin
                coef_o = '0;
            end
        endcase
    end

endmodule

// ==== hdl/ga_pkg.sv ====
package ga_pkg;

    localparam int N_LANES = 16;
    localparam int COEF_W  = 16;
    localparam int FRAC_W  = 11;
    localparam int ACC_W   = 40;
    localparam int N_BASIS = 5;

    typedef logic signed [COEF_W-1:0]  ga_coef_t;
    typedef logic [N_LANES*COEF_W-1:0] ga_mv_t;
    typedef logic signed [ACC_W-1:0]   ga_acc_t;
    typedef logic [3:0]                ga_lane_idx_t;
    typedef logic [N_BASIS-1:0]        ga_blade_mask_t;

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_MUL   = 3'd2,
        OP_WEDGE = 3'd3,
        OP_REV   = 3'd4,
        OP_NORM  = 3'd5
    } ga_op_e;

    localparam ga_coef_t COEF_MAX = 16'sh7FFF;
    localparam ga_coef_t COEF_MIN = 16'sh8000;

    // bit i set means e(i+1) is part of the blade
    localparam ga_blade_mask_t LANE_MASK [N_LANES] = '{
        5'b00000,
        5'b00011, 5'b00101, 5'b00110, 5'b01001, 5'b01010,
        5'b01100, 5'b10001, 5'b10010, 5'b10100, 5'b11000,
        5'b01111, 5'b10111, 5'b11011, 5'b11101, 5'b11110
    };

    function automatic ga_lane_idx_t mask_to_lane(ga_blade_mask_t mask);
        ga_lane_idx_t idx;
        idx = '0;
        for (int k = 0; k < N_LANES; k++) begin
            if (LANE_MASK[k] == mask) begin
                idx = ga_lane_idx_t'(k);
            end
        end
        return idx;
    endfunction

    // swaps needed to bring a*b into canonical order, e5 squares to -1
    function automatic logic signed [1:0] blade_sign(ga_blade_mask_t ma, ga_blade_mask_t mb);
        logic flip;
        flip = ma[N_BASIS-1] & mb[N_BASIS-1];
        for (int i = 0; i < N_BASIS; i++) begin
            for (int k = i + 1; k < N_BASIS; k++) begin
                flip = flip ^ (mb[i] & ma[k]);
            end
        end
        return flip ? -2'sd1 : 2'sd1;
    endfunction

    function automatic ga_coef_t sat_coef(ga_acc_t x);
        if (x > ga_acc_t'(COEF_MAX)) begin
            return COEF_MAX;
        end
        if (x < ga_acc_t'(COEF_MIN)) begin
            return COEF_MIN;
        end
        return x[COEF_W-1:0];
    endfunction

    // round half up at the last fraction bit, then clip
    function automatic ga_coef_t round_sat(ga_acc_t acc);
        ga_acc_t rounded;
        rounded = (acc + ga_acc_t'(1 <<< (FRAC_W - 1))) >>> FRAC_W;
        return sat_coef(rounded);
    endfunction

    function automatic ga_coef_t sat_add(ga_coef_t x, ga_coef_t y);
        return sat_coef(ga_acc_t'(x) + ga_acc_t'(y));
    endfunction

endpackage

// ==== hdl/ga_req_if.sv ====
`timescale 1ns/1ps

interface ga_req_if;
    import ga_pkg::*;

    logic   valid;
    // ready doubles as the pop strobe
    logic   ready;
    ga_op_e op;
    ga_mv_t a;
    ga_mv_t b;

    modport fifo_side (
        output valid, op, a, b,
        input  ready
    );

    modport engine_side (
        input  valid, op, a, b,
        output ready
    );

endinterface

// ==== hdl/ga_request_fifo.sv ====
`timescale 1ns/1ps

module ga_request_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic           clk_i,
    input  logic           rst_ni,
    input  logic           push_valid_i,
    input  ga_pkg::ga_op_e push_op_i,
    input  ga_pkg::ga_mv_t push_a_i,
    input  ga_pkg::ga_mv_t push_b_i,
    output logic           push_ready_o,
    ga_req_if.fifo_side    req
);
    import ga_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    ga_op_e           op_mem [FIFO_DEPTH];
    ga_mv_t           a_mem  [FIFO_DEPTH];
    ga_mv_t           b_mem  [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    // depth need not be a power of two
    function automatic logic [PTR_W-1:0] next_ptr(logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign push_ready_o = (count_q != CNT_W'(FIFO_DEPTH));
    assign push         = push_valid_i && push_ready_o;
    assign pop          = req.valid && req.ready;

    // head entry shown whenever something is queued
    assign req.valid = (count_q != '0);
    assign req.op    = op_mem[rd_ptr_q];
    assign req.a     = a_mem[rd_ptr_q];
    assign req.b     = b_mem[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push) begin
            op_mem[wr_ptr_q] <= push_op_i;
            a_mem[wr_ptr_q]  <= push_a_i;
            b_mem[wr_ptr_q]  <= push_b_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module ga_alu_tb -f ga_alu.f \
    -Mdir obj_dir -o ga_alu_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/ga_alu_sim > sim.log 2>&1
grep -q "Test failures found" sim.log && { echo "simulation FAILED, see sim.log"; exit 1; }
grep -q "All tests passed!" sim.log && echo "simulation passed" \
    || { echo "simulation ended without a pass line, see sim.log"; exit 1; }

// ==== verif/ga_alu_tb.sv ====
`timescale 1ns/1ps

module ga_alu_tb;
    import ga_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int N_ROWS     = 13;
    localparam int N_RAND     = 24;
    localparam int MAX_CYCLES = (N_ROWS + N_RAND) * (N_LANES + 3) + 200;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        valid_i;
    ga_op_e      operation_i;
    ga_mv_t      operand_a_i;
    ga_mv_t      operand_b_i;
    logic        ready_o;
    ga_mv_t      result_o;
    logic        valid_o;
    ga_op_e      row_op [N_ROWS];
    ga_mv_t      row_a [N_ROWS];
    ga_mv_t      row_b [N_ROWS];
    ga_mv_t      row_exp [N_ROWS];
    ga_mv_t      exp_q [$];
    int          accept_cyc_q [$];
    bit          isolated_q [$];
    ga_mv_t      cur_exp = '0;
    bit          isolated = 1'b0;
    bit          burst_mode = 1'b0;
    bit          full_seen = 1'b0;
    int          burst_accepts = 0;
    int          accepted = 0;
    int          results = 0;
    int          cyc = 0;
    logic [15:0] lfsr_q = 16'd94;

    ga_alu_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut_i (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .valid_i     (valid_i),
        .operation_i (operation_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .ready_o     (ready_o),
        .result_o    (result_o),
        .valid_o     (valid_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_mv(input ga_mv_t exp, input ga_mv_t act);
        int bad;
        bad = -1;
        for (int k = N_LANES - 1; k >= 0; k--) begin
            if (act[k*COEF_W +: COEF_W] !== exp[k*COEF_W +: COEF_W]) begin
                bad = k;
            end
        end
        if (bad >= 0) begin
            abort_run($sformatf("error at %0t ns: lane %0d expected %h actual %h", $time, bad,
                                exp[bad*COEF_W +: COEF_W], act[bad*COEF_W +: COEF_W]));
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (exp != act) begin
            abort_run($sformatf("error at %0t ns: %s expected %0d actual %0d",
                                $time, what, exp, act));
        end
    endtask

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[14:0], lfsr_q[0]};
        end
    endtask

    // coefficients stay within +-2.0 so that sums do not always clip
    task automatic rand_mv(output ga_mv_t m);
        logic [15:0] v;
        for (int k = 0; k < N_LANES; k++) begin
            rand_bits(13, v);
            m[k*COEF_W +: COEF_W] = {{3{v[12]}}, v[12:0]};
        end
    endtask

    function automatic ga_mv_t lane_mv(int k, ga_coef_t v);
        ga_mv_t m;
        m = '0;
        m[k*COEF_W +: COEF_W] = v;
        return m;
    endfunction

    function automatic longint lane_val(ga_mv_t m, int k);
        ga_coef_t c;
        c = m[k*COEF_W +: COEF_W];
        return longint'(c);
    endfunction

    // scalar, then bivectors by highest index, then the 4-blades missing e5 down to e1
    function automatic ga_blade_mask_t blade_of(int k);
        ga_blade_mask_t m;
        int             n;
        m = '0;
        n = 1;
        if (k >= 11) begin
            return ga_blade_mask_t'(5'b11111 ^ (5'b10000 >> (k - 11)));
        end
        for (int hi = 1; hi < 5; hi++) begin
            for (int lo = 0; lo < hi; lo++) begin
                if (n == k) begin
                    m = ga_blade_mask_t'((1 << hi) | (1 << lo));
                end
                n++;
            end
        end
        return m;
    endfunction

    function automatic int lane_of_blade(ga_blade_mask_t m);
        int idx;
        idx = 0;
        for (int k = 0; k < N_LANES; k++) begin
            if (blade_of(k) == m) begin
                idx = k;
            end
        end
        return idx;
    endfunction

    // each vector of b moves left past the higher vectors of a
    function automatic int blade_product_sign(ga_blade_mask_t ma, ga_blade_mask_t mb);
        int swaps;
        swaps = (ma[4] && mb[4]) ? 1 : 0;
        for (int i = 0; i < 5; i++) begin
            if (mb[i]) begin
                swaps += $countones(ma >> (i + 1));
            end
        end
        return swaps[0] ? -1 : 1;
    endfunction

    function automatic ga_coef_t clamp16(longint x);
        if (x > 32767) begin
            return 16'sh7FFF;
        end
        if (x < -32768) begin
            return 16'sh8000;
        end
        return ga_coef_t'(x);
    endfunction

    function automatic ga_mv_t model_result(ga_op_e op, ga_mv_t a, ga_mv_t b);
        ga_mv_t         r;
        longint         acc;
        ga_blade_mask_t mj;
        ga_blade_mask_t mp;
        r = '0;
        for (int i = 0; i < N_LANES; i++) begin
            acc = 0;
            case (op)
                OP_ADD: acc = lane_val(a, i) + lane_val(b, i);
                OP_SUB: acc = lane_val(a, i) - lane_val(b, i);
                OP_REV: acc = ($countones(blade_of(i)) == 2) ? -lane_val(a, i) : lane_val(a, i);
                OP_NORM: begin
                    for (int j = 0; j < N_LANES && i == 0; j++) begin
                        acc += lane_val(a, j) * lane_val(a, j);
                    end
                    acc = (acc + 1024) >>> 11;
                end
                OP_MUL, OP_WEDGE: begin
                    for (int j = 0; j < N_LANES; j++) begin
                        mj = blade_of(j);
                        mp = mj ^ blade_of(i);
                        if (op == OP_MUL || (mj & mp) == '0) begin
                            acc += blade_product_sign(mj, mp) * lane_val(a, j)
                                   * lane_val(b, lane_of_blade(mp));
                        end
                    end
                    acc = (acc + 1024) >>> 11;
                end
                default: acc = 0;
            endcase
            r[i*COEF_W +: COEF_W] = clamp16(acc);
        end
        return r;
    endfunction

    task automatic set_row(input int r, input ga_op_e op, input ga_mv_t a, input ga_mv_t b,
                           input ga_mv_t exp);
        row_op[r]  = op;
        row_a[r]   = a;
        row_b[r]   = b;
        row_exp[r] = exp;
    endtask

    // hand-worked results in Q5.11 where 1.0 is 0x0800
    task automatic load_table();
        set_row(0, OP_ADD, lane_mv(0, 16'h0800) | lane_mv(5, 16'h1000),
                lane_mv(0, 16'h0400) | lane_mv(5, 16'hF800),
                lane_mv(0, 16'h0C00) | lane_mv(5, 16'h0800));
        set_row(1, OP_ADD, {N_LANES{16'h7000}}, {N_LANES{16'h7000}}, {N_LANES{16'h7FFF}});
        set_row(2, OP_SUB, {N_LANES{16'h9000}}, {N_LANES{16'h7000}}, {N_LANES{16'h8000}});
        set_row(3, OP_SUB, lane_mv(2, 16'h0400), lane_mv(2, 16'h0C00) | lane_mv(14, 16'h8000),
                lane_mv(2, 16'hF800) | lane_mv(14, 16'h7FFF));
        set_row(4, OP_REV, lane_mv(0, 16'h0100) | lane_mv(3, 16'h8000) | lane_mv(7, 16'h0200)
                | lane_mv(12, 16'h8000), '0, lane_mv(0, 16'h0100) | lane_mv(3, 16'h7FFF)
                | lane_mv(7, 16'hFE00) | lane_mv(12, 16'h8000));
        // 1 + 4 + 4 = 9.0
        set_row(5, OP_NORM, lane_mv(0, 16'h0800) | lane_mv(4, 16'h1000) | lane_mv(13, 16'hF000),
                '0, lane_mv(0, 16'h4800));
        set_row(6, OP_NORM, lane_mv(0, 16'h3000), '0, lane_mv(0, 16'h7FFF));
        set_row(7, OP_MUL, lane_mv(1, 16'h0800), lane_mv(1, 16'h0800), lane_mv(0, 16'hF800));
        set_row(8, OP_MUL, lane_mv(7, 16'h0800), lane_mv(7, 16'h0800), lane_mv(0, 16'h0800));
        // 3 * 0x400 lands exactly on the half step and rounds up
        set_row(9, OP_MUL, lane_mv(0, 16'h0003), lane_mv(0, 16'h0400), lane_mv(0, 16'h0002));
        set_row(10, OP_WEDGE, lane_mv(1, 16'h0800), lane_mv(6, 16'h0800), lane_mv(11, 16'h0800));
        set_row(11, OP_WEDGE, lane_mv(1, 16'h0800), lane_mv(2, 16'h0800), '0);
        set_row(12, ga_op_e'(3'd6), {N_LANES{16'h1234}}, {N_LANES{16'h0567}}, '0);
    endtask

    // holds the request until ready_o and returns just after the accepting edge
    task automatic send_req(input ga_op_e op, input ga_mv_t a, input ga_mv_t b,
                            input ga_mv_t exp);
        valid_i     = 1'b1;
        operation_i = op;
        operand_a_i = a;
        operand_b_i = b;
        cur_exp     = exp;
        do begin
            @(negedge clk_i);
        end while (!ready_o);
        @(posedge clk_i);
        #2;
    endtask

    task automatic wait_results();
        do begin
            @(posedge clk_i);
        end while (exp_q.size() != 0);
        #2;
    endtask

    // mid-cycle view of the handshake and the result
    always @(negedge clk_i) begin : monitor
        int lat;
        if (rst_ni && valid_i && ready_o) begin
            exp_q.push_back(cur_exp);
            accept_cyc_q.push_back(cyc + 1);
            isolated_q.push_back(isolated);
            accepted++;
            if (burst_mode && !full_seen) begin
                burst_accepts++;
            end
        end
        if (rst_ni && burst_mode && valid_i && !ready_o && !full_seen) begin
            full_seen = 1'b1;
            check_count(FIFO_DEPTH + 1, burst_accepts, "requests accepted before ready_o fell");
        end
        if (rst_ni && valid_o) begin
            // every pulse counts, a stray one shows up in the final count
            results++;
            if (exp_q.size() != 0) begin
                check_mv(exp_q.pop_front(), result_o);
                lat = cyc - accept_cyc_q.pop_front();
                if (isolated_q.pop_front()) begin
                    check_count(N_LANES + 2, lat, "edges from acceptance to valid_o");
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cyc++;
        if (cyc > MAX_CYCLES) begin
            abort_run($sformatf("timeout: the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    initial begin
        ga_op_e      op;
        ga_mv_t      a;
        ga_mv_t      b;
        logic [15:0] v;
        rst_ni      = 1'b0;
        valid_i     = 1'b0;
        operation_i = OP_ADD;
        operand_a_i = '0;
        operand_b_i = '0;
        load_table();
        repeat (10) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        check_count(1, int'(ready_o), "ready_o after reset");
        check_count(0, int'(valid_o), "valid_o after reset");

        // directed rows run one at a time through the pipeline
        isolated = 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            send_req(row_op[r], row_a[r], row_b[r], row_exp[r]);
            valid_i = 1'b0;
            wait_results();
        end

        // random requests back to back until the FIFO pushes back
        isolated   = 1'b0;
        burst_mode = 1'b1;
        for (int r = 0; r < N_RAND; r++) begin
            rand_bits(3, v);
            op = ga_op_e'(v[2:0]);
            rand_mv(a);
            rand_mv(b);
            send_req(op, a, b, model_result(op, a, b));
        end
        valid_i = 1'b0;
        wait_results();
        // idle window long enough for one more result to appear
        repeat (N_LANES + 3) @(posedge clk_i);
        if (!full_seen) begin
            abort_run("ready_o never fell during the back-to-back requests");
        end
        check_count(accepted, results, "results seen on valid_o");
        $display("All tests passed!");
        $finish;
    end

endmodule
